// File: organ_macros.svh
`ifndef ORGAN_MACROS_SVH
`define ORGAN_MACROS_SVH

// ====================
// Datapath widths
// ====================

// Signed audio sample
`define ORGAN_SAMPLE_W 8

// Tone half-period counter
`define ORGAN_DIVISOR_W 32

// Speed offset and scope sampling divisor
`define ORGAN_SPEED_W 16

// ====================
// Control constants
// ====================

// Speed change per key event
`define ORGAN_SPEED_STEP 100

// Scope divisor at zero speed, about 2 kHz sampling
`define ORGAN_DEFAULT_SCOPE_COUNT 12499

// Ten repeat ticks per second at 50 MHz
`define ORGAN_REPEAT_CYCLES 5000000

`define ORGAN_NUM_DIGITS 6

`endif

// File: organ_pkg.sv
`include "organ_macros.svh"

package organ_pkg;

  // ====================
  // Types
  // ====================

  // Do Re Mi Fa So La Si Do2, 523 Hz up to 1046 Hz
  typedef enum logic [2:0]
  {
    do_note,
    re_note,
    mi_note,
    fa_note,
    so_note,
    la_note,
    si_note,
    do2_note
  } note_t;

  typedef logic [`ORGAN_DIVISOR_W-1:0] divisor_t;
  typedef logic signed [`ORGAN_SAMPLE_W-1:0] sample_t;
  typedef logic signed [`ORGAN_SPEED_W-1:0] speed_t;

  // Segments gfedcba, lit when low
  typedef logic [6:0] seg_t;

  // Key levels, active high after inversion
  typedef logic [2:0] key_t;

  localparam int key_up_bit = 0;
  localparam int key_down_bit = 1;
  localparam int key_reset_bit = 2;

  // Full-scale square wave levels
  localparam sample_t sample_hi = 8'sh7F;
  localparam sample_t sample_lo = 8'sh80;

  // ====================
  // Lookup functions
  // ====================

  // Half-period in 50 MHz cycles
  function automatic divisor_t note_divisor(input note_t note);
    divisor_t div;
    unique case (note)
      do_note:  div = 32'd47800;
      re_note:  div = 32'd42590;
      mi_note:  div = 32'd37936;
      fa_note:  div = 32'd35817;
      so_note:  div = 32'd31929;
      la_note:  div = 32'd28409;
      si_note:  div = 32'd25329;
      do2_note: div = 32'd23900;
      default:  div = 32'd47800;
    endcase
    return div;
  endfunction

  function automatic seg_t seg_decode(input logic [3:0] nibble);
    seg_t seg;
    unique case (nibble)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;
      4'hE: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

endpackage

// File: input_sync.sv
`timescale 1ns/1ps

module input_sync #(
  parameter type data_t = logic,
  parameter data_t reset_value = '0
) (
  input  logic  CLK_50M,
  input  logic  arst_n,
  input  data_t d,
  output data_t q
);

  // First stage may go metastable
  data_t meta_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      meta_q <= reset_value;
      q      <= reset_value;
    end
    else
    begin
      meta_q <= d;
      q      <= meta_q;
    end
  end

endmodule

// File: key_event_gen.sv
`timescale 1ns/1ps
`include "organ_macros.svh"

module key_event_gen #(
  parameter int unsigned repeat_cycles = `ORGAN_REPEAT_CYCLES
) (
  input  logic             CLK_50M,
  input  logic             arst_n,
  input  organ_pkg::key_t  keys,
  output logic             up_event,
  output logic             down_event,
  output logic             reset_level
);

  localparam int cnt_w = (repeat_cycles > 1) ? $clog2(repeat_cycles) : 1;
  localparam logic [cnt_w-1:0] tick_last = cnt_w'(repeat_cycles - 1);

  logic [cnt_w-1:0] tick_cnt;
  logic             tick;

  // ====================
  // Repeat tick
  // ====================

  assign tick = (tick_cnt == tick_last);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt <= '0;
    end
    else if (tick)
    begin
      tick_cnt <= '0;
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // ====================
  // Event pulses
  // ====================

  // Held key fires once per tick, so holding repeats at the tick rate
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_event   <= 1'b0;
      down_event <= 1'b0;
    end
    else
    begin
      up_event   <= tick & keys[organ_pkg::key_up_bit];
      down_event <= tick & keys[organ_pkg::key_down_bit];
    end
  end

  // Reset acts every cycle it is held
  assign reset_level = keys[organ_pkg::key_reset_bit];

endmodule

// File: speed_control.sv
`timescale 1ns/1ps
`include "organ_macros.svh"

module speed_control (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  logic                      up_event,
  input  logic                      down_event,
  input  logic                      reset_level,
  output logic [`ORGAN_SPEED_W-1:0] scope_divisor
);

  localparam organ_pkg::speed_t speed_step = organ_pkg::speed_t'(`ORGAN_SPEED_STEP);
  localparam logic [`ORGAN_SPEED_W-1:0] default_count =
    `ORGAN_SPEED_W'(`ORGAN_DEFAULT_SCOPE_COUNT);

  organ_pkg::speed_t speed;

  // Speed offset, wraps on overflow
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      speed <= '0;
    end
    else if (reset_level)
    begin
      speed <= '0;
    end
    else
    begin
      case ({up_event, down_event})
        2'b10:   speed <= speed + speed_step;
        2'b01:   speed <= speed - speed_step;
        // Both at once cancel out
        default: speed <= speed;
      endcase
    end
  end

  // Sampling divisor one cycle behind speed
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      scope_divisor <= default_count;
    end
    else
    begin
      scope_divisor <= default_count + $unsigned(speed);
    end
  end

endmodule

// File: tone_generator.sv
`timescale 1ns/1ps

module tone_generator (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic                enable,
  input  organ_pkg::note_t    note,
  output organ_pkg::sample_t  audio_sample
);

  organ_pkg::divisor_t half_period;
  organ_pkg::divisor_t half_cnt;
  organ_pkg::note_t    note_q;
  logic                wave;

  assign half_period = organ_pkg::note_divisor(note);

  // ====================
  // Square-wave divider
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      note_q   <= organ_pkg::do_note;
      half_cnt <= '0;
      wave     <= 1'b0;
    end
    else
    begin
      note_q <= note;
      if (note != note_q)
      begin
        // New note starts a fresh half-period
        half_cnt <= '0;
      end
      else if (half_cnt == half_period - 1'b1)
      begin
        half_cnt <= '0;
        wave     <= ~wave;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // ====================
  // Sample forming
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      audio_sample <= organ_pkg::sample_lo;
    end
    else
    begin
      audio_sample <= (wave && enable) ? organ_pkg::sample_hi : organ_pkg::sample_lo;
    end
  end

endmodule

// File: hex_display.sv
`timescale 1ns/1ps
`include "organ_macros.svh"

module hex_display (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  logic [`ORGAN_SPEED_W-1:0] value,
  output organ_pkg::seg_t           hex0,
  output organ_pkg::seg_t           hex1,
  output organ_pkg::seg_t           hex2,
  output organ_pkg::seg_t           hex3,
  output organ_pkg::seg_t           hex4,
  output organ_pkg::seg_t           hex5
);

  localparam int pad_w = 4 * `ORGAN_NUM_DIGITS;

  logic [pad_w-1:0] padded;
  organ_pkg::seg_t  digit_q [`ORGAN_NUM_DIGITS];

  // Upper nibbles stay zero
  assign padded = pad_w'(value);

  // ====================
  // Per-digit decode
  // ====================

  for (genvar i = 0; i < `ORGAN_NUM_DIGITS; i++)
  begin : g_digit
    always_ff @(posedge CLK_50M or negedge arst_n)
    begin
      if (!arst_n)
      begin
        digit_q[i] <= organ_pkg::seg_decode(4'h0);
      end
      else
      begin
        digit_q[i] <= organ_pkg::seg_decode(padded[4*i +: 4]);
      end
    end
  end

  // hex0 is the least significant digit
  assign hex0 = digit_q[0];
  assign hex1 = digit_q[1];
  assign hex2 = digit_q[2];
  assign hex3 = digit_q[3];
  assign hex4 = digit_q[4];
  assign hex5 = digit_q[5];

endmodule

// File: organ_top.sv
`timescale 1ns/1ps
`include "organ_macros.svh"

module organ_top #(
  parameter int unsigned repeat_cycles = `ORGAN_REPEAT_CYCLES
) (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  logic [3:0]                sw,
  input  logic [2:0]                key,
  output organ_pkg::sample_t        audio_sample,
  output logic [`ORGAN_SPEED_W-1:0] scope_divisor,
  output organ_pkg::seg_t           hex0,
  output organ_pkg::seg_t           hex1,
  output organ_pkg::seg_t           hex2,
  output organ_pkg::seg_t           hex3,
  output organ_pkg::seg_t           hex4,
  output organ_pkg::seg_t           hex5
);

  // sw_q[0] is enable, sw_q[3:1] the note
  logic [3:0]      sw_q;
  organ_pkg::key_t keys_q;
  logic            up_event;
  logic            down_event;
  logic            reset_level;

  // ====================
  // Input synchronizers
  // ====================

  input_sync #(
    .data_t      (logic [3:0]),
    .reset_value (4'h0)
  ) sw_sync (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .d       (sw),
    .q       (sw_q)
  );

  // Keys are active low on the board
  input_sync #(
    .data_t      (organ_pkg::key_t),
    .reset_value ('0)
  ) key_sync (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .d       (organ_pkg::key_t'(~key)),
    .q       (keys_q)
  );

  // ====================
  // Speed path
  // ====================

  key_event_gen #(
    .repeat_cycles (repeat_cycles)
  ) i_key_event_gen (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .keys        (keys_q),
    .up_event    (up_event),
    .down_event  (down_event),
    .reset_level (reset_level)
  );

  speed_control i_speed_control (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .up_event      (up_event),
    .down_event    (down_event),
    .reset_level   (reset_level),
    .scope_divisor (scope_divisor)
  );

  hex_display i_hex_display (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .value   (scope_divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

  // ====================
  // Tone path
  // ====================

  tone_generator i_tone_generator (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .enable       (sw_q[0]),
    .note         (organ_pkg::note_t'(sw_q[3:1])),
    .audio_sample (audio_sample)
  );

endmodule

// File: organ_sva.sv
`timescale 1ns/1ps

module organ_sva (
  input logic       CLK_50M,
  input logic       arst_n,
  input logic [7:0] audio_sample,
  input logic       up_event,
  input logic       down_event,
  input logic       enable
);

  // Only the two full-scale levels
  a_sample_levels: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    (audio_sample == 8'h80) || (audio_sample == 8'h7F)
  ) else $error("audio_sample left the two square-wave levels");

  a_up_single: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    up_event |=> !up_event
  ) else $error("up_event lasted two cycles");

  a_down_single: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    down_event |=> !down_event
  ) else $error("down_event lasted two cycles");

  // Sample register follows enable one cycle later
  a_gated: assert property (
    @(posedge CLK_50M) disable iff (!arst_n)
    !enable |=> (audio_sample == 8'h80)
  ) else $error("audio_sample not silent while enable is low");

endmodule

bind organ_top organ_sva i_organ_sva (
  .CLK_50M      (CLK_50M),
  .arst_n       (arst_n),
  .audio_sample (audio_sample),
  .up_event     (up_event),
  .down_event   (down_event),
  .enable       (sw_q[0])
);

// File: tb_organ.sv
`timescale 1ns/1ps

module tb_organ;

  localparam int repeat_cycles = 50;
  localparam int timeout_cycles = 1500000;

  logic        CLK_50M;
  logic        arst_n;
  logic [3:0]  sw;
  logic [2:0]  key;
  logic [7:0]  audio_sample;
  logic [15:0] scope_divisor;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;

  // Divisor that the key stimulus should have produced
  logic [15:0] model_div;

  int total_checks = 0;
  int total_errs = 0;
  int tests_done = 0;
  int digit_checks = 0;
  int digit_errs = 0;
  int cycle_cnt = 0;

  organ_top #(
    .repeat_cycles (repeat_cycles)
  ) i_dut (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .sw            (sw),
    .key           (key),
    .audio_sample  (audio_sample),
    .scope_divisor (scope_divisor),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ====================
  // Reference model
  // ====================

  // Half-period in cycles for Do up to Do2
  function automatic int exp_divisor(input logic [2:0] note);
    int table_div [8];
    table_div = '{47800, 42590, 37936, 35817, 31929, 28409, 25329, 23900};
    return table_div[note];
  endfunction

  function automatic logic [15:0] exp_scope(input int steps);
    return 16'(12499 + 100 * steps);
  endfunction

  // Active low segments with bit 0 as segment a
  function automatic logic [6:0] exp_seg(input logic [3:0] nibble);
    logic [6:0] table_seg [16];
    table_seg = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    return table_seg[nibble];
  endfunction

  // ====================
  // Helpers
  // ====================

  task automatic check_value(input string name, input int exp, input int act, inout int errs);
    total_checks++;
    if (exp != act)
    begin
      total_errs++;
      errs++;
      $display("error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic check_digits(input string name, input logic [23:0] value, inout int errs);
    check_value({name, " hex0"}, exp_seg(value[3:0]), hex0, errs);
    check_value({name, " hex1"}, exp_seg(value[7:4]), hex1, errs);
    check_value({name, " hex2"}, exp_seg(value[11:8]), hex2, errs);
    check_value({name, " hex3"}, exp_seg(value[15:12]), hex3, errs);
    check_value({name, " hex4"}, exp_seg(value[19:16]), hex4, errs);
    check_value({name, " hex5"}, exp_seg(value[23:20]), hex5, errs);
  endtask

  task automatic drive(input logic [3:0] sw_v, input logic [2:0] key_v);
    @(posedge CLK_50M);
    #2;
    sw  = sw_v;
    key = key_v;
  endtask

  task automatic wait_sample_change(output int cycles);
    logic [7:0] prev;
    prev = audio_sample;
    cycles = 0;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
    end while (audio_sample == prev);
  endtask

  task automatic wait_divisor_change();
    logic [15:0] prev;
    prev = scope_divisor;
    do
      @(negedge CLK_50M);
    while (scope_divisor == prev);
  endtask

  task automatic report_test(input string name, input int errs);
    tests_done++;
    $display("%s: done, %0d mismatches", name, errs);
  endtask

  // Digits follow every settled divisor one cycle later
  initial
  begin : digit_monitor
    logic [15:0] prev_div;
    int stable;
    prev_div = '0;
    stable = -1;
    forever
    begin
      @(negedge CLK_50M);
      if (!arst_n)
        stable = -1;
      else if (scope_divisor != prev_div)
        stable = 0;
      else if (stable < 2)
        stable++;
      prev_div = scope_divisor;
      if (stable == 1)
      begin
        digit_checks++;
        check_digits("digits", {8'h00, model_div}, digit_errs);
      end
    end
  end

  // Run limit for 8 notes of three half-periods plus the key tests
  initial
  begin
    while (cycle_cnt < timeout_cycles)
    begin
      @(posedge CLK_50M);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

  // ====================
  // Stimulus
  // ====================

  initial
  begin : main
    integer seed;
    logic [2:0] order [8];
    logic [2:0] tmp;
    logic [7:0] bad;
    int errs;
    int cycles;
    int changes;
    int steps;
    int i;
    int j;

    seed = 32'hd0947d51;
    model_div = exp_scope(0);
    sw = 4'h0;
    key = 3'b111;
    arst_n = 1'b0;
    repeat (2) @(posedge CLK_50M);
    #2;
    arst_n = 1'b1;

    // Reset state
    errs = 0;
    @(negedge CLK_50M);
    check_value("reset_state divisor", 12499, scope_divisor, errs);
    check_value("reset_state sample", 8'h80, audio_sample, errs);
    repeat (2) @(negedge CLK_50M);
    check_digits("reset_state", 24'h0030D3, errs);
    report_test("reset_state", errs);

    // Note periods in shuffled order
    errs = 0;
    for (i = 0; i < 8; i++)
      order[i] = 3'(i);
    for (i = 7; i > 0; i--)
    begin
      j = {$random(seed)} % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < 8; i++)
    begin
      drive({order[i], 1'b1}, 3'b111);
      repeat (4) @(negedge CLK_50M);
      // Interval right after the note change is not a full one
      wait_sample_change(cycles);
      for (j = 0; j < 2; j++)
      begin
        wait_sample_change(cycles);
        check_value("note_periods", exp_divisor(order[i]), cycles, errs);
      end
    end
    report_test("note_periods", errs);

    // Enable gating
    errs = 0;
    bad = 8'h80;
    drive(4'b0000, 3'b111);
    repeat (4) @(negedge CLK_50M);
    repeat (47800 + 200)
    begin
      @(negedge CLK_50M);
      if (audio_sample != 8'h80)
        bad = audio_sample;
    end
    check_value("enable_gating", 8'h80, bad, errs);
    report_test("enable_gating", errs);

    // Speed up by five steps
    errs = 0;
    steps = 0;
    drive(4'b0000, 3'b110);
    for (i = 0; i < 5; i++)
    begin
      wait_divisor_change();
      steps++;
      model_div = exp_scope(steps);
      check_value("speed_up step", model_div, scope_divisor, errs);
    end
    drive(4'b0000, 3'b111);
    changes = 0;
    repeat (3 * repeat_cycles)
    begin
      @(negedge CLK_50M);
      if (scope_divisor != exp_scope(steps))
        changes++;
    end
    check_value("speed_up changes after release", 0, changes, errs);
    check_value("speed_up final", exp_scope(5), scope_divisor, errs);
    report_test("speed_up", errs);

    // Speed down past zero and then the reset key
    errs = 0;
    drive(4'b0000, 3'b101);
    for (i = 0; i < 8; i++)
    begin
      wait_divisor_change();
      steps--;
      model_div = exp_scope(steps);
      check_value("speed_down step", model_div, scope_divisor, errs);
    end
    drive(4'b0000, 3'b111);
    repeat (3 * repeat_cycles) @(negedge CLK_50M);
    check_value("speed_down final", exp_scope(-3), scope_divisor, errs);
    model_div = exp_scope(0);
    drive(4'b0000, 3'b011);
    repeat (8) @(negedge CLK_50M);
    drive(4'b0000, 3'b111);
    repeat (8) @(negedge CLK_50M);
    check_value("speed_reset", 12499, scope_divisor, errs);
    report_test("speed_down_reset", errs);

    if (digit_checks == 0)
    begin
      total_errs++;
      digit_errs++;
      $display("digits: no settled scope divisor was ever seen");
    end
    report_test("digits", digit_errs);

    $display("%0d tests, %0d checks, %0d mismatches", tests_done, total_checks, total_errs);
    if (total_errs == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+.
organ_pkg.sv
input_sync.sv
key_event_gen.sv
speed_control.sv
tone_generator.sv
hex_display.sv
organ_top.sv
organ_sva.sv
tb_organ.sv

// File: Bender.yml
package:
  name: student_organ

export_include_dirs:
  - .

sources:
  - organ_pkg.sv
  - input_sync.sv
  - key_event_gen.sv
  - speed_control.sv
  - tone_generator.sv
  - hex_display.sv
  - organ_top.sv
  - target: test
    files:
      - organ_sva.sv
      - tb_organ.sv
